// ==== Bender.yml ====
package:
  name: mmu

sources:
  - files:
      - hw/tlb_pkg.sv
      - hw/cp0_pkg.sv
      - hw/cp0_tlb_if.sv
      - hw/tlb_array.sv
      - hw/tlb_random_counter.sv
      - hw/tlb_op_fsm.sv
      - hw/cp0_tlb_regs.sv
      - hw/tlb_translate.sv
      - hw/mmu_top.sv
  - target: test
    files:
      - tests/mmu_asserts.sv
      - tests/tb_mmu.sv

// ==== hw/cp0_pkg.sv ====
/* CP0 register selects are local codes, not the MIPS register numbers.
   Only the TLB related registers exist here. */
package cp0_pkg;

    localparam int CP0_DATA_W = 32;

    typedef enum logic [2:0] {
        REG_INDEX,
        REG_RANDOM,                           // read only
        REG_ENTRYLO0,
        REG_ENTRYLO1,
        REG_ENTRYHI
    } cp0_reg_t;

    typedef enum logic [1:0] {
        OP_TLBP,
        OP_TLBR,
        OP_TLBWI,
        OP_TLBWR
    } tlb_op_t;

    // one operation in flight at a time
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_DONE
    } tlb_fsm_state_t;

endpackage

// ==== hw/cp0_tlb_if.sv ====
/* Shared bus between CP0 registers, operation sequencer, Random counter and TLB array.
   Strobes from the sequencer are single cycle and act on the next clock edge. */
interface cp0_tlb_if import tlb_pkg::*; ();

    tlb_index_t index;
    vpn2_t      entry_hi_vpn2;
    asid_t      entry_hi_asid;                // current ASID for both search ports
    tlb_page_t  entry_lo0;
    logic       entry_lo0_g;
    tlb_page_t  entry_lo1;
    logic       entry_lo1_g;

    tlb_index_t random;

    tlb_entry_t rd_entry;                     // entry at index, for TLBR
    logic       probe_found;
    tlb_index_t probe_index;

    logic       tlb_we;
    logic       wr_sel_random;                // TLBWR when high, else TLBWI
    logic       probe_en;
    logic       probe_load;
    logic       read_load;

    modport regs (
        output index, entry_hi_vpn2, entry_hi_asid,
        output entry_lo0, entry_lo0_g, entry_lo1, entry_lo1_g,
        input  random, rd_entry, probe_found, probe_index, probe_load, read_load
    );

    modport array (
        input  index, entry_hi_vpn2, entry_hi_asid,
        input  entry_lo0, entry_lo0_g, entry_lo1, entry_lo1_g,
        input  random, tlb_we, wr_sel_random, probe_en,
        output rd_entry, probe_found, probe_index
    );

    modport fsm (
        output tlb_we, wr_sel_random, probe_en, probe_load, read_load
    );

    modport rnd (
        output random
    );

endinterface

// ==== hw/cp0_tlb_regs.sv ====
/* MIPS32 bit layout for Index, EntryHi and EntryLo; Index.P is set only by TLBP.
   TLBP and TLBR updates win over a software write in the same cycle. */
module cp0_tlb_regs import tlb_pkg::*, cp0_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cp0_we,
    input  cp0_reg_t              cp0_addr,
    input  logic [CP0_DATA_W-1:0] cp0_wdata,
    output logic [CP0_DATA_W-1:0] cp0_rdata,
    cp0_tlb_if.regs               tlb
);

    logic probe_fail;                         // Index.P, bit 31

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlb.index  <= '0;
            probe_fail <= 1'b0;
        end else if (tlb.probe_load) begin
            probe_fail <= ~tlb.probe_found;
            tlb.index  <= tlb.probe_found ? tlb.probe_index : '0;
        end else if (cp0_we && cp0_addr == REG_INDEX) begin
            tlb.index <= cp0_wdata[TLB_IDX_W-1:0];   // P left alone
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlb.entry_hi_vpn2 <= '0;
            tlb.entry_hi_asid <= '0;
            tlb.entry_lo0     <= '0;
            tlb.entry_lo0_g   <= 1'b0;
            tlb.entry_lo1     <= '0;
            tlb.entry_lo1_g   <= 1'b0;
        end else if (tlb.read_load) begin
            tlb.entry_hi_vpn2 <= tlb.rd_entry.vpn2;
            tlb.entry_hi_asid <= tlb.rd_entry.asid;
            tlb.entry_lo0     <= tlb.rd_entry.page0;
            tlb.entry_lo0_g   <= tlb.rd_entry.g;
            tlb.entry_lo1     <= tlb.rd_entry.page1;
            tlb.entry_lo1_g   <= tlb.rd_entry.g;
        end else if (cp0_we) begin
            case (cp0_addr)
                REG_ENTRYHI: begin
                    tlb.entry_hi_vpn2 <= cp0_wdata[31:13];
                    tlb.entry_hi_asid <= cp0_wdata[7:0];
                end
                REG_ENTRYLO0: begin
                    tlb.entry_lo0   <= cp0_wdata[25:1];   // pfn, c, d, v
                    tlb.entry_lo0_g <= cp0_wdata[0];
                end
                REG_ENTRYLO1: begin
                    tlb.entry_lo1   <= cp0_wdata[25:1];
                    tlb.entry_lo1_g <= cp0_wdata[0];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (cp0_addr)
            REG_INDEX:    cp0_rdata = {probe_fail, {(CP0_DATA_W-1-TLB_IDX_W){1'b0}}, tlb.index};
            REG_RANDOM:   cp0_rdata = {{(CP0_DATA_W-TLB_IDX_W){1'b0}}, tlb.random};
            REG_ENTRYLO0: cp0_rdata = {6'b0, tlb.entry_lo0, tlb.entry_lo0_g};
            REG_ENTRYLO1: cp0_rdata = {6'b0, tlb.entry_lo1, tlb.entry_lo1_g};
            REG_ENTRYHI:  cp0_rdata = {tlb.entry_hi_vpn2, 5'b0, tlb.entry_hi_asid};
            default:      cp0_rdata = '0;
        endcase
    end

endmodule

// ==== hw/mmu_top.sv ====
/* Every address is mapped, kseg0/kseg1 are not special; no exceptions are generated.
   The fetch port never stores, so it never reports modified. */
module mmu_top import tlb_pkg::*, cp0_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  vaddr_t                inst_va,
    input  vaddr_t                data_va,
    input  logic                  data_store,
    input  logic                  cp0_we,
    input  cp0_reg_t              cp0_addr,
    input  logic [CP0_DATA_W-1:0] cp0_wdata,
    input  logic                  tlb_op_valid,
    input  tlb_op_t               tlb_op,
    output paddr_t                inst_pa,
    output logic                  inst_miss,
    output logic                  inst_invalid,
    output paddr_t                data_pa,
    output logic                  data_miss,
    output logic                  data_invalid,
    output logic                  data_modified,
    output logic [CP0_DATA_W-1:0] cp0_rdata,
    output logic                  tlb_busy,
    output logic                  tlb_done
);

    logic       inst_found;
    logic       data_found;
    tlb_entry_t inst_entry;
    tlb_entry_t data_entry;

    cp0_tlb_if tlb_bus ();

    tlb_array i_tlb_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_vpn2  (inst_va[31:13]),
        .data_vpn2  (data_va[31:13]),
        .tlb        (tlb_bus.array),
        .inst_found (inst_found),
        .inst_entry (inst_entry),
        .data_found (data_found),
        .data_entry (data_entry)
    );

    tlb_random_counter i_random (
        .clk   (clk),
        .rst_n (rst_n),
        .tlb   (tlb_bus.rnd)
    );

    tlb_op_fsm i_op_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .tlb_op_valid (tlb_op_valid),
        .tlb_op       (tlb_op),
        .tlb          (tlb_bus.fsm),
        .tlb_busy     (tlb_busy),
        .tlb_done     (tlb_done)
    );

    cp0_tlb_regs i_cp0_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cp0_we    (cp0_we),
        .cp0_addr  (cp0_addr),
        .cp0_wdata (cp0_wdata),
        .cp0_rdata (cp0_rdata),
        .tlb       (tlb_bus.regs)
    );

    tlb_translate i_inst_xlate (
        .va       (inst_va),
        .found    (inst_found),
        .entry    (inst_entry),
        .store    (1'b0),
        .pa       (inst_pa),
        .miss     (inst_miss),
        .invalid  (inst_invalid),
        .modified ()                          // fetch does not store
    );

    tlb_translate i_data_xlate (
        .va       (data_va),
        .found    (data_found),
        .entry    (data_entry),
        .store    (data_store),
        .pa       (data_pa),
        .miss     (data_miss),
        .invalid  (data_invalid),
        .modified (data_modified)
    );

endmodule

// ==== hw/tlb_array.sv ====
/* Fully associative, both search ports are combinational in the same cycle.
   Multiple hits resolve to the lowest index; a probe takes over the data port. */
module tlb_array import tlb_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  vpn2_t       inst_vpn2,
    input  vpn2_t       data_vpn2,
    cp0_tlb_if.array    tlb,
    output logic        inst_found,
    output tlb_entry_t  inst_entry,
    output logic        data_found,
    output tlb_entry_t  data_entry
);

    localparam int NUM_PORTS = 2;             // 0 = fetch, 1 = data / probe

    tlb_entry_t entries [TLB_NUM];

    tlb_index_t wr_idx;
    tlb_entry_t wr_entry;

    vpn2_t      srch_vpn2  [NUM_PORTS];
    logic       srch_found [NUM_PORTS];
    tlb_index_t srch_idx   [NUM_PORTS];

    // write side, Index or Random
    assign wr_idx = tlb.wr_sel_random ? tlb.random : tlb.index;

    always_comb begin
        wr_entry.vpn2  = tlb.entry_hi_vpn2;
        wr_entry.asid  = tlb.entry_hi_asid;
        wr_entry.g     = tlb.entry_lo0_g & tlb.entry_lo1_g;   // global only if both halves say so
        wr_entry.page0 = tlb.entry_lo0;
        wr_entry.page1 = tlb.entry_lo1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                entries[i] <= '0;
            end
        end else if (tlb.tlb_we) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    // indexed read for TLBR
    assign tlb.rd_entry = entries[tlb.index];

    assign srch_vpn2[0] = inst_vpn2;
    assign srch_vpn2[1] = tlb.probe_en ? tlb.entry_hi_vpn2 : data_vpn2;   // probe borrows data port

    // compare against every entry, walk downward so the lowest hit sticks
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            srch_found[p] = 1'b0;
            srch_idx[p]   = '0;
            for (int i = TLB_NUM - 1; i >= 0; i--) begin
                if (entries[i].vpn2 == srch_vpn2[p] &&
                    (entries[i].g || entries[i].asid == tlb.entry_hi_asid)) begin
                    srch_found[p] = 1'b1;
                    srch_idx[p]   = tlb_index_t'(i);
                end
            end
        end
    end

    assign inst_found = srch_found[0];
    assign inst_entry = entries[srch_idx[0]];   // don't care on a miss
    assign data_found = srch_found[1];
    assign data_entry = entries[srch_idx[1]];

    // probe result straight from the data port
    assign tlb.probe_found = srch_found[1];
    assign tlb.probe_index = srch_idx[1];

endmodule

// ==== hw/tlb_op_fsm.sv ====
/* Accepts one operation per pulse; tlb_done follows the accepted pulse by 2 cycles.
   Pulses while busy are dropped, there is no queue. */
module tlb_op_fsm import cp0_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     tlb_op_valid,
    input  tlb_op_t  tlb_op,
    cp0_tlb_if.fsm   tlb,
    output logic     tlb_busy,
    output logic     tlb_done
);

    tlb_fsm_state_t state;
    tlb_fsm_state_t state_nxt;
    tlb_op_t        op_q;                     // operation held through ST_EXEC

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (tlb_op_valid) state_nxt = ST_EXEC;
            ST_EXEC: state_nxt = ST_DONE;
            ST_DONE: state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && tlb_op_valid) begin
            op_q <= tlb_op;
        end
    end

    // exactly one action per operation, only in ST_EXEC
    always_comb begin
        tlb.tlb_we        = 1'b0;
        tlb.wr_sel_random = 1'b0;
        tlb.probe_en      = 1'b0;
        tlb.probe_load    = 1'b0;
        tlb.read_load     = 1'b0;
        if (state == ST_EXEC) begin
            case (op_q)
                OP_TLBP: begin
                    tlb.probe_en   = 1'b1;
                    tlb.probe_load = 1'b1;
                end
                OP_TLBR:  tlb.read_load = 1'b1;
                OP_TLBWI: tlb.tlb_we    = 1'b1;
                OP_TLBWR: begin
                    tlb.tlb_we        = 1'b1;
                    tlb.wr_sel_random = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign tlb_busy = (state != ST_IDLE);
    assign tlb_done = (state == ST_DONE);

endmodule

// ==== hw/tlb_pkg.sv ====
/* 4 KB pages only, no page mask and no Wired register.
   TLB_NUM must stay a power of two so that the Random counter wraps cleanly. */
package tlb_pkg;

    localparam int TLB_NUM    = 16;
    localparam int TLB_IDX_W  = $clog2(TLB_NUM);
    localparam int PAGE_OFS_W = 12;           // 4 KB page offset

    typedef logic [TLB_IDX_W-1:0] tlb_index_t;
    typedef logic [18:0]          vpn2_t;     // va[31:13], one even/odd page pair
    typedef logic [7:0]           asid_t;
    typedef logic [19:0]          pfn_t;
    typedef logic [2:0]           cache_attr_t;
    typedef logic [31:0]          vaddr_t;
    typedef logic [31:0]          paddr_t;

    // same order as EntryLo bits 25:1
    typedef struct packed {
        pfn_t        pfn;
        cache_attr_t c;
        logic        d;                       // dirty, page is writable
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        vpn2_t     vpn2;
        asid_t     asid;
        logic      g;                         // global, asid ignored on match
        tlb_page_t page0;                     // even page, va[12] = 0
        tlb_page_t page1;                     // odd page
    } tlb_entry_t;

endpackage

// ==== hw/tlb_random_counter.sv ====
/* Decrements every cycle, no Wired floor, so any slot can be replaced by TLBWR. */
module tlb_random_counter import tlb_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    cp0_tlb_if.rnd  tlb
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlb.random <= tlb_index_t'(TLB_NUM - 1);
        end else if (tlb.random == '0) begin
            tlb.random <= tlb_index_t'(TLB_NUM - 1);   // wrap to the top slot
        end else begin
            tlb.random <= tlb.random - 1'b1;
        end
    end

endmodule

// ==== hw/tlb_translate.sv ====
/* Purely combinational; the flags are raw status, no exception is raised here. */
module tlb_translate import tlb_pkg::*; (
    input  vaddr_t     va,
    input  logic       found,
    input  tlb_entry_t entry,
    input  logic       store,
    output paddr_t     pa,
    output logic       miss,
    output logic       invalid,
    output logic       modified
);

    tlb_page_t page;

    // va[12] picks the odd page of the pair
    assign page = va[PAGE_OFS_W] ? entry.page1 : entry.page0;

    assign pa = {page.pfn, va[PAGE_OFS_W-1:0]};

    assign miss     = ~found;
    assign invalid  = found & ~page.v;
    assign modified = found & page.v & store & ~page.d;   // store to a clean page

endmodule

// ==== tb.f ====
hw/tlb_pkg.sv
hw/cp0_pkg.sv
hw/cp0_tlb_if.sv
hw/tlb_array.sv
hw/tlb_random_counter.sv
hw/tlb_op_fsm.sv
hw/cp0_tlb_regs.sv
hw/tlb_translate.sv
hw/mmu_top.sv
tests/mmu_asserts.sv
tests/tb_mmu.sv

// ==== tests/mmu_asserts.sv ====
/* Bound into tlb_op_fsm, so the strobes are seen as the sequencer drives them.
   Reset is synchronous, outputs are checked one edge after rst_n is sampled low. */
module mmu_asserts (
    input logic clk,
    input logic rst_n,
    input logic tlb_op_valid,
    input logic tlb_busy,
    input logic tlb_done,
    input logic tlb_we,
    input logic probe_en
);

    int assert_errs = 0;                      // failed assertion count

    property idle_in_reset;
        @(posedge clk) !rst_n |=> (!tlb_busy && !tlb_done);
    endproperty

    // accepted only when idle
    property done_after_two;
        @(posedge clk) disable iff (!rst_n)
            (tlb_op_valid && !tlb_busy) |-> ##2 tlb_done;
    endproperty

    property write_or_probe;
        @(posedge clk) disable iff (!rst_n) !(tlb_we && probe_en);
    endproperty

    a_idle_in_reset: assert property (idle_in_reset)
        else begin
            $error("busy or done high during reset");
            assert_errs++;
        end
    a_done_after_two: assert property (done_after_two)
        else begin
            $error("tlb_done missing 2 cycles after an accepted pulse");
            assert_errs++;
        end
    a_write_or_probe: assert property (write_or_probe)
        else begin
            $error("tlb_we and probe_en high together");
            assert_errs++;
        end

endmodule

// ==== tests/tb_mmu.sv ====
/* Random TLB test with seed 84 against a reference model of entries and CP0 registers.
   TLBWR slots are learned by a TLBP afterwards; inputs change on the falling edge. */
module tb_mmu import tlb_pkg::*, cp0_pkg::*; ();

    localparam int NUM_OPS        = 24;                     // TLB operations issued below
    localparam int TIMEOUT_CYCLES = 20 * NUM_OPS + 1000;    // margin covers writes and lookups
    localparam int HIT            = TLB_IDX_W;              // found bit above the index

    logic clk, rst_n, cp0_we, tlb_op_valid, data_store;
    cp0_reg_t cp0_addr;
    logic [CP0_DATA_W-1:0] cp0_wdata, cp0_rdata;
    tlb_op_t tlb_op;
    vaddr_t inst_va, data_va;
    paddr_t inst_pa, data_pa;
    logic inst_miss, inst_invalid, data_miss, data_invalid, data_modified;
    logic tlb_busy, tlb_done;

    integer seed = 84;
    int cycles = 0;
    int pa_errs = 0, flag_errs = 0, cp0_errs = 0, seq_errs = 0;

    // reference model
    tlb_entry_t m_tlb [TLB_NUM];
    tlb_index_t m_index;
    logic       m_pfail, m_g0, m_g1;
    vpn2_t      m_hi_vpn2;
    asid_t      m_hi_asid;
    tlb_page_t  m_lo0, m_lo1;

    mmu_top i_dut (.*);

    bind tlb_op_fsm mmu_asserts i_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .tlb_op_valid (tlb_op_valid),
        .tlb_busy     (tlb_busy),
        .tlb_done     (tlb_done),
        .tlb_we       (tlb.tlb_we),
        .probe_en     (tlb.probe_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_pa(input paddr_t got, input paddr_t exp, input string what);
        if (got !== exp) begin
            pa_errs++;
            $display("Fail %0t: %s pa %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail %0t: %s miss/invalid/modified %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cp0(input logic [CP0_DATA_W-1:0] got, input logic [CP0_DATA_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            cp0_errs++;
            $display("Fail %0t: %s read %h expected %h", $time, what, got, exp);
        end
    endtask

    // lowest matching index wins, found flag on top
    function automatic logic [HIT:0] model_search(input vpn2_t vpn2);
        for (int i = 0; i < TLB_NUM; i++) begin
            if (m_tlb[i].vpn2 == vpn2 && (m_tlb[i].g || m_tlb[i].asid == m_hi_asid)) begin
                return {1'b1, tlb_index_t'(i)};
            end
        end
        return '0;
    endfunction

    function automatic tlb_page_t model_page(input vaddr_t va);
        logic [HIT:0] hit;
        hit = model_search(va[31:13]);
        return va[12] ? m_tlb[hit[HIT-1:0]].page1 : m_tlb[hit[HIT-1:0]].page0;
    endfunction

    function automatic logic [2:0] flags_expect(input vaddr_t va, input logic st);
        tlb_page_t    pg;
        logic [HIT:0] hit;
        pg  = model_page(va);
        hit = model_search(va[31:13]);
        if (!hit[HIT]) return 3'b100;
        return {1'b0, ~pg.v, pg.v & st & ~pg.d};
    endfunction

    function automatic logic [CP0_DATA_W-1:0] cp0_expect(input cp0_reg_t r);
        logic [CP0_DATA_W-1:0] v;
        v = '0;
        case (r)
            REG_INDEX: begin
                v[31] = m_pfail;
                v[TLB_IDX_W-1:0] = m_index;
            end
            REG_ENTRYHI: begin
                v[31:13] = m_hi_vpn2;
                v[7:0]   = m_hi_asid;
            end
            REG_ENTRYLO0: v[25:0] = {m_lo0, m_g0};
            REG_ENTRYLO1: v[25:0] = {m_lo1, m_g1};
            default: ;
        endcase
        return v;
    endfunction

    function automatic void model_op(input tlb_op_t op, input tlb_index_t slot);
        logic [HIT:0] hit;
        tlb_entry_t   e;
        hit     = model_search(m_hi_vpn2);
        e.vpn2  = m_hi_vpn2;
        e.asid  = m_hi_asid;
        e.g     = m_g0 & m_g1;
        e.page0 = m_lo0;
        e.page1 = m_lo1;
        case (op)
            OP_TLBP: begin
                m_pfail = ~hit[HIT];
                m_index = hit[HIT] ? hit[HIT-1:0] : '0;
            end
            OP_TLBR: begin
                m_hi_vpn2 = m_tlb[m_index].vpn2;
                m_hi_asid = m_tlb[m_index].asid;
                m_lo0     = m_tlb[m_index].page0;
                m_lo1     = m_tlb[m_index].page1;
                m_g0      = m_tlb[m_index].g;
                m_g1      = m_tlb[m_index].g;
            end
            OP_TLBWI: m_tlb[m_index] = e;
            default:  m_tlb[slot] = e;
        endcase
    endfunction

    // nonzero and unused, so probes and lookups see one match
    function automatic vpn2_t fresh_vpn2();
        vpn2_t v;
        logic  clash;
        do begin
            v     = vpn2_t'($random(seed));
            clash = (v == '0);
            for (int i = 0; i < TLB_NUM; i++) begin
                if (m_tlb[i].vpn2 == v) clash = 1'b1;
            end
        end while (clash);
        return v;
    endfunction

    function automatic vaddr_t va_in(input vpn2_t vpn2);
        return {vpn2, 13'($random(seed))};
    endfunction

    function automatic logic [25:0] make_lo(input logic d, input logic v, input logic g);
        return {pfn_t'($random(seed)), cache_attr_t'($random(seed)), d, v, g};
    endfunction

    task automatic cp0_write(input cp0_reg_t r, input logic [CP0_DATA_W-1:0] d);
        cp0_we    = 1'b1;
        cp0_addr  = r;
        cp0_wdata = d;
        @(negedge clk);
        cp0_we = 1'b0;
        case (r)
            REG_INDEX:    m_index = d[TLB_IDX_W-1:0];   // P bit untouched
            REG_ENTRYHI: begin
                m_hi_vpn2 = d[31:13];
                m_hi_asid = d[7:0];
            end
            REG_ENTRYLO0: {m_lo0, m_g0} = d[25:0];
            REG_ENTRYLO1: {m_lo1, m_g1} = d[25:0];
            default: ;
        endcase
    endtask

    task automatic read_check(input cp0_reg_t r, input string what);
        cp0_addr = r;
        @(negedge clk);
        check_cp0(cp0_rdata, cp0_expect(r), what);
    endtask

    task automatic load_regs(input vpn2_t vpn2, input asid_t asid,
                             input logic [25:0] lo0, input logic [25:0] lo1);
        cp0_write(REG_ENTRYHI, {vpn2, 5'b0, asid});
        cp0_write(REG_ENTRYLO0, {6'b0, lo0});
        cp0_write(REG_ENTRYLO1, {6'b0, lo1});
    endtask

    // poke sends a TLBWI pulse while busy, which must be dropped
    task automatic run_op(input tlb_op_t op, input logic poke);
        int waited;
        tlb_op_valid = 1'b1;
        tlb_op       = op;
        @(negedge clk);
        tlb_op_valid = poke;                  // held through ST_EXEC and ST_DONE
        tlb_op       = OP_TLBWI;
        waited       = 1;
        while (!tlb_done && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (waited != 2) begin
            seq_errs++;
            $display("Fail %0t: tlb_done came %0d cycles after the accepted pulse, not 2",
                     $time, waited);
        end
        @(negedge clk);
        tlb_op_valid = 1'b0;
        if (tlb_busy !== 1'b0) begin
            seq_errs++;
            $display("Fail %0t: tlb_busy still high after tlb_done", $time);
        end
    endtask

    task automatic write_indexed(input tlb_index_t idx, input logic poke);
        cp0_write(REG_INDEX, CP0_DATA_W'(idx));
        run_op(OP_TLBWI, poke);
        model_op(OP_TLBWI, '0);
    endtask

    task automatic write_random(input logic poke);
        tlb_index_t slot;
        run_op(OP_TLBWR, poke);
        run_op(OP_TLBP, 1'b0);
        cp0_addr = REG_INDEX;
        @(negedge clk);
        slot = cp0_rdata[TLB_IDX_W-1:0];
        if (cp0_rdata[31] !== 1'b0) begin
            cp0_errs++;
            $display("Fail %0t: TLBP found no entry right after a TLBWR", $time);
        end
        model_op(OP_TLBWR, slot);
        model_op(OP_TLBP, '0);
    endtask

    task automatic lookup(input vaddr_t iva, input vaddr_t dva, input logic st);
        logic [2:0] iexp;
        logic [2:0] dexp;
        tlb_page_t  ipg;
        tlb_page_t  dpg;
        inst_va    = iva;
        data_va    = dva;
        data_store = st;
        @(negedge clk);
        iexp = flags_expect(iva, 1'b0);       // fetch never stores
        dexp = flags_expect(dva, st);
        ipg  = model_page(iva);
        dpg  = model_page(dva);
        check_flags({inst_miss, inst_invalid, 1'b0}, iexp, "inst");
        check_flags({data_miss, data_invalid, data_modified}, dexp, "data");
        if (!iexp[2]) check_pa(inst_pa, {ipg.pfn, iva[11:0]}, "inst");
        if (!dexp[2]) check_pa(data_pa, {dpg.pfn, dva[11:0]}, "data");
    endtask

    initial begin
        vpn2_t v;
        vpn2_t v2;
        rst_n = 1'b0;
        cp0_we = 1'b0;
        cp0_addr = REG_INDEX;
        cp0_wdata = '0;
        tlb_op_valid = 1'b0;
        tlb_op = OP_TLBP;
        inst_va = '0;
        data_va = '0;
        data_store = 1'b0;
        for (int i = 0; i < TLB_NUM; i++) m_tlb[i] = '0;
        {m_index, m_pfail, m_g0, m_g1, m_hi_vpn2, m_hi_asid, m_lo0, m_lo1} = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        lookup(32'h0000_0000, 32'h0000_1ffc, 1'b1);   // cleared entries hit as invalid

        // random entries at random Index
        for (int n = 0; n < 8; n++) begin
            v = fresh_vpn2();
            load_regs(v, asid_t'($random(seed)), 26'($random(seed)), 26'($random(seed)));
            write_indexed(tlb_index_t'($random(seed)), n[0]);
            repeat (6) lookup(va_in(v), va_in(v), 1'($random(seed)));
            repeat (4) lookup(vaddr_t'($random(seed)), vaddr_t'($random(seed)), 1'b1);
        end

        // ASID match and global entries
        v = fresh_vpn2();
        load_regs(v, 8'h11, make_lo(1'b1, 1'b1, 1'b0), make_lo(1'b1, 1'b1, 1'b0));
        write_indexed(5, 1'b0);
        lookup(va_in(v), va_in(v), 1'b0);
        cp0_write(REG_ENTRYHI, {v, 5'b0, 8'h22});
        lookup(va_in(v), va_in(v), 1'b0);
        v2 = fresh_vpn2();
        load_regs(v2, 8'h22, make_lo(1'b1, 1'b1, 1'b1), make_lo(1'b0, 1'b1, 1'b1));
        write_indexed(6, 1'b0);
        cp0_write(REG_ENTRYHI, {v2, 5'b0, 8'h33});
        lookup(va_in(v2), va_in(v), 1'b0);

        // even page invalid, odd page valid but clean
        v = fresh_vpn2();
        load_regs(v, 8'h33, make_lo(1'b1, 1'b0, 1'b0), make_lo(1'b0, 1'b1, 1'b0));
        write_indexed(7, 1'b0);
        lookup({v, 13'h0abc}, {v, 13'h0abc}, 1'b1);
        lookup({v, 13'h1abc}, {v, 13'h1abc}, 1'b1);
        lookup({v, 13'h1abc}, {v, 13'h1abc}, 1'b0);

        // probe hit, read back, probe miss
        cp0_write(REG_ENTRYHI, {m_tlb[5].vpn2, 5'b0, m_tlb[5].asid});
        run_op(OP_TLBP, 1'b0);
        model_op(OP_TLBP, '0);
        read_check(REG_INDEX, "index after probe hit");
        cp0_write(REG_ENTRYLO0, 32'h03ff_ffff);
        cp0_write(REG_ENTRYLO1, 32'h0123_4567);
        run_op(OP_TLBR, 1'b1);
        model_op(OP_TLBR, '0);
        read_check(REG_ENTRYHI, "entryhi after read");
        read_check(REG_ENTRYLO0, "entrylo0 after read");
        read_check(REG_ENTRYLO1, "entrylo1 after read");
        cp0_write(REG_ENTRYHI, {fresh_vpn2(), 5'b0, 8'h44});
        run_op(OP_TLBP, 1'b0);
        model_op(OP_TLBP, '0);
        read_check(REG_INDEX, "index after probe miss");

        // random replacement, then duplicates at 9 and 3
        for (int n = 0; n < 4; n++) begin
            v = fresh_vpn2();
            load_regs(v, 8'h44, 26'($random(seed)), 26'($random(seed)));
            write_random(n[0]);
            lookup(va_in(v), va_in(v), 1'($random(seed)));
        end
        v = fresh_vpn2();
        load_regs(v, 8'h44, make_lo(1'b1, 1'b1, 1'b0), make_lo(1'b1, 1'b1, 1'b0));
        write_indexed(9, 1'b0);
        cp0_write(REG_ENTRYLO0, {6'b0, make_lo(1'b0, 1'b1, 1'b0)});
        cp0_write(REG_ENTRYLO1, {6'b0, make_lo(1'b1, 1'b0, 1'b0)});   // both halves differ
        write_indexed(3, 1'b1);
        repeat (4) lookup(va_in(v), va_in(v), 1'($random(seed)));

        $display("errors: pa %0d, flags %0d, cp0 %0d, sequencer %0d, assertions %0d",
                 pa_errs, flag_errs, cp0_errs, seq_errs,
                 i_dut.i_op_fsm.i_asserts.assert_errs);
        if (pa_errs + flag_errs + cp0_errs + seq_errs +
            i_dut.i_op_fsm.i_asserts.assert_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
